//--- Bender.yml
package:
  name: digital_clock

sources:
  - clock_pkg.sv
  - tick_gen.sv
  - button_pulse.sv
  - mode_ctrl.sv
  - time_counters.sv
  - display_mux.sv
  - digital_clock_top.sv
  - target: test
    files:
      - tb_digital_clock.sv

//--- all.f
clock_pkg.sv
tick_gen.sv
button_pulse.sv
mode_ctrl.sv
time_counters.sv
display_mux.sv
digital_clock_top.sv
tb_digital_clock.sv

//--- button_pulse.sv
/*
 * Button debouncer
 * Synchronizes four push buttons, filters them on the debounce
 * tick and gives one press pulse per debounced rising edge
 */
`default_nettype none

module button_pulse (
	input  wire        clk,
	input  wire        rst_n,
	input  wire        i_deb_tick,
	input  wire  [3:0] i_btn,    // mode, pos, inc, alarm
	output logic [3:0] o_press
);

	localparam int NBTN = 4;

	logic [NBTN-1:0] sync1;
	logic [NBTN-1:0] sync2;
	logic [NBTN-1:0] samp;     // previous debounce sample
	logic [NBTN-1:0] level;    // stable level
	logic [NBTN-1:0] level_d;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1   <= '0;
			sync2   <= '0;
			samp    <= '0;
			level   <= '0;
			level_d <= '0;
		end else begin
			sync1   <= i_btn;
			sync2   <= sync1;
			level_d <= level;
			if (i_deb_tick) begin
				samp <= sync2;
				for (int b = 0; b < NBTN; b++) begin
					if (sync2[b] == samp[b])
						level[b] <= sync2[b]; // two equal samples in a row
				end
			end
		end
	end

	assign o_press = level & ~level_d;

endmodule

`default_nettype wire

//--- clock_pkg.sv
/*
 * Digital clock shared definitions
 * Field widths and limits, mode and position enums,
 * seven-segment patterns and decimal-point patterns
 */
`default_nettype none

package clock_pkg;

	// ----------------------------------------
	// Time fields
	// ----------------------------------------
	localparam int HMS_W    = 6;
	typedef logic [HMS_W-1:0] hms_t;

	localparam int SEC_MAX  = 59;
	localparam int MIN_MAX  = 59;
	localparam int HOUR_MAX = 23;

	// ----------------------------------------
	// Display
	// ----------------------------------------
	localparam int DIGITS = 6;
	localparam int SEG_W  = 7;
	typedef logic [SEG_W-1:0]  seg_t;      // a in bit 6 .. g in bit 0
	typedef logic [DIGITS-1:0] digit_en_t; // active low

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC  = 2'd0,
		POS_MIN  = 2'd1,
		POS_HOUR = 2'd2
	} pos_e;

	localparam seg_t SEG_BLANK = 7'b000_0000;

	localparam logic [DIGITS-1:0] DP_CLOCK = 6'b010101; // hh.mm.ss separators
	localparam logic [DIGITS-1:0] DP_SETUP = 6'b000001;
	localparam logic [DIGITS-1:0] DP_ALARM = 6'b000010;

	localparam seg_t SEG_DIGIT [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

endpackage

`default_nettype wire

//--- digital_clock_top.sv
/*
 * Digital clock top level
 * Buttons to tick generator, mode FSM, time counters and the
 * multiplexed seven-segment display
 */
`default_nettype none

module digital_clock_top #(
	parameter int SEC_DIV  = 50_000_000,
	parameter int SCAN_DIV = 5_000,
	parameter int DEB_DIV  = 500_000
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  i_btn_mode,
	input  wire                  i_btn_pos,
	input  wire                  i_btn_inc,
	input  wire                  i_btn_alarm,
	output clock_pkg::seg_t      o_seg,
	output logic                 o_seg_dp,
	output clock_pkg::digit_en_t o_seg_enb,
	output logic                 o_alarm
);

	import clock_pkg::*;

	logic  sec_tick, blink_on, scan_tick, deb_tick;
	logic  mode_press, pos_press, inc_press, alarm_press;
	mode_e mode;
	pos_e  pos;
	logic  alarm_en;
	hms_t  clk_sec, clk_min, clk_hour;
	hms_t  al_sec, al_min, al_hour;

	tick_gen #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV),
		.DEB_DIV  (DEB_DIV)
	) u_tick_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.o_sec_tick  (sec_tick),
		.o_blink_on  (blink_on),
		.o_scan_tick (scan_tick),
		.o_deb_tick  (deb_tick)
	);

	button_pulse u_button_pulse (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_deb_tick (deb_tick),
		.i_btn      ({i_btn_mode, i_btn_pos, i_btn_inc, i_btn_alarm}),
		.o_press    ({mode_press, pos_press, inc_press, alarm_press})
	);

	mode_ctrl u_mode_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_press    ({mode_press, pos_press, inc_press, alarm_press}),
		.o_mode     (mode),
		.o_pos      (pos),
		.o_alarm_en (alarm_en)
	);

	time_counters u_time_counters (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_sec_tick  (sec_tick),
		.i_inc_press (inc_press),
		.i_mode      (mode),
		.i_pos       (pos),
		.i_alarm_en  (alarm_en),
		.o_clk_sec   (clk_sec),
		.o_clk_min   (clk_min),
		.o_clk_hour  (clk_hour),
		.o_al_sec    (al_sec),
		.o_al_min    (al_min),
		.o_al_hour   (al_hour),
		.o_alarm     (o_alarm)
	);

	display_mux u_display_mux (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_blink_on  (blink_on),
		.i_mode      (mode),
		.i_pos       (pos),
		.i_clk_sec   (clk_sec),
		.i_clk_min   (clk_min),
		.i_clk_hour  (clk_hour),
		.i_al_sec    (al_sec),
		.i_al_min    (al_min),
		.i_al_hour   (al_hour),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

`default_nettype wire

//--- display_mux.sv
/*
 * Display multiplexer
 * Selects clock or alarm time, decodes six digits with field
 * blinking and scans them one at a time onto the segment bus
 */
`default_nettype none

module display_mux (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  i_scan_tick,
	input  wire                  i_blink_on,
	input  clock_pkg::mode_e     i_mode,
	input  clock_pkg::pos_e      i_pos,
	input  clock_pkg::hms_t      i_clk_sec,
	input  clock_pkg::hms_t      i_clk_min,
	input  clock_pkg::hms_t      i_clk_hour,
	input  clock_pkg::hms_t      i_al_sec,
	input  clock_pkg::hms_t      i_al_min,
	input  clock_pkg::hms_t      i_al_hour,
	output clock_pkg::seg_t      o_seg,
	output logic                 o_seg_dp,
	output clock_pkg::digit_en_t o_seg_enb
);

	import clock_pkg::*;

	localparam int NFLD  = 3;
	localparam int IDX_W = $clog2(DIGITS);

	hms_t              fld [NFLD];   // sec, min, hour
	logic [3:0]        dig [DIGITS];
	seg_t              dseg [DIGITS];
	logic [DIGITS-1:0] dp_pat;
	logic              editing;
	logic [IDX_W-1:0]  scan_idx;
	logic              scan_d;

	assign editing = (i_mode == MODE_SETUP) || (i_mode == MODE_ALARM);

	// ----------------------------------------
	// Digit decode
	// ----------------------------------------
	always_comb begin
		fld[0] = (i_mode == MODE_ALARM) ? i_al_sec : i_clk_sec;
		fld[1] = (i_mode == MODE_ALARM) ? i_al_min : i_clk_min;
		fld[2] = (i_mode == MODE_ALARM) ? i_al_hour : i_clk_hour;
		for (int i = 0; i < NFLD; i++) begin
			dig[2*i]     = 4'(fld[i] % 10);  // ones
			dig[2*i + 1] = 4'(fld[i] / 10);  // tens
			if (editing && !i_blink_on && (int'(i_pos) == i)) begin
				dseg[2*i]     = SEG_BLANK;
				dseg[2*i + 1] = SEG_BLANK;
			end else begin
				dseg[2*i]     = SEG_DIGIT[dig[2*i]];
				dseg[2*i + 1] = SEG_DIGIT[dig[2*i + 1]];
			end
		end
	end

	always_comb begin
		case (i_mode)
			MODE_SETUP: dp_pat = DP_SETUP;
			MODE_ALARM: dp_pat = DP_ALARM;
			default:    dp_pat = DP_CLOCK;
		endcase
	end

	// ----------------------------------------
	// Scan
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_idx <= '0;
			scan_d   <= 1'b0;
		end else begin
			scan_d <= i_scan_tick;
			if (i_scan_tick)
				scan_idx <= (scan_idx == IDX_W'(DIGITS - 1)) ? '0 : scan_idx + 1'b1;
		end
	end

	// Outputs load the cycle after each scan step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= SEG_BLANK;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= '1;        // all digits off
		end else if (scan_d) begin
			o_seg     <= dseg[scan_idx];
			o_seg_dp  <= dp_pat[scan_idx];
			o_seg_enb <= ~(digit_en_t'(1) << scan_idx);
		end
	end

endmodule

`default_nettype wire

//--- mode_ctrl.sv
/*
 * Mode controller
 * Steps the display mode and the selected field on button
 * presses and toggles the alarm enable
 */
`default_nettype none

module mode_ctrl (
	input  wire              clk,
	input  wire              rst_n,
	input  wire        [3:0] i_press,   // mode, pos, inc, alarm
	output clock_pkg::mode_e o_mode,
	output clock_pkg::pos_e  o_pos,
	output logic             o_alarm_en
);

	import clock_pkg::*;

	logic mode_press;
	logic pos_press;
	logic alarm_press;
	logic editing;

	assign mode_press  = i_press[3];
	assign pos_press   = i_press[2];
	assign alarm_press = i_press[0];
	assign editing     = (o_mode == MODE_SETUP) || (o_mode == MODE_ALARM);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode <= MODE_CLOCK;
			o_pos  <= POS_SEC;
		end else if (mode_press) begin
			o_pos <= POS_SEC;
			case (o_mode)
				MODE_CLOCK: o_mode <= MODE_SETUP;
				MODE_SETUP: o_mode <= MODE_ALARM;
				default:    o_mode <= MODE_CLOCK;
			endcase
		end else if (pos_press && editing) begin
			case (o_pos)
				POS_SEC: o_pos <= POS_MIN;
				POS_MIN: o_pos <= POS_HOUR;
				default: o_pos <= POS_SEC;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm_en <= 1'b0;
		else if (alarm_press)
			o_alarm_en <= ~o_alarm_en;  // any mode
	end

endmodule

`default_nettype wire

//--- tb_digital_clock.sv
/*
 * Digital clock testbench
 * Presses the four buttons, rebuilds the six displayed digits
 * from the scanned segment bus and checks timekeeping, setup,
 * alarm setting and the alarm latch
 */
`default_nettype none

module tb_digital_clock;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEC_DIV  = 400;
	localparam int SCAN_DIV = 4;
	localparam int DEB_DIV  = 4;
	localparam int DIGITS   = 6;
	localparam int DAY      = 24 * 3600;
	localparam int LEAD     = 5;          // alarm lead in seconds
	localparam int BAD      = 15;
	localparam logic [5:0] DP_CLK = 6'b010101;
	localparam logic [5:0] DP_SET = 6'b000001;
	localparam logic [5:0] DP_ALM = 6'b000010;
	localparam int B_MODE  = 3;
	localparam int B_POS   = 2;
	localparam int B_INC   = 1;
	localparam int B_ALARM = 0;

	logic       clk   = 1'b0;
	logic       rst_n = 1'b0;
	logic [3:0] btn   = '0;      // mode, pos, inc, alarm
	logic [6:0] seg;
	logic       seg_dp;
	logic [5:0] seg_enb;
	logic       alarm;

	// Display shadow written only by the monitor
	logic [6:0] shadow_seg [DIGITS];
	logic [5:0] shadow_dp = '0;
	int         upd_cnt   [DIGITS] = '{default: 0};
	int         blank_cnt [DIGITS] = '{default: 0};
	int         lit_cnt   [DIGITS] = '{default: 0};
	logic       scan_seen = 1'b0;

	int   cyc         = 0;
	int   n_fail      = 0;
	int   n_timeout   = 0;
	logic alarm_quiet = 1'b1;
	logic alarm_hold  = 1'b0;

	digital_clock_top #(
		.SEC_DIV  (SEC_DIV),
		.SCAN_DIV (SCAN_DIV),
		.DEB_DIV  (DEB_DIV)
	) dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn[B_MODE]),
		.i_btn_pos   (btn[B_POS]),
		.i_btn_inc   (btn[B_INC]),
		.i_btn_alarm (btn[B_ALARM]),
		.o_seg       (seg),
		.o_seg_dp    (seg_dp),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		if (rst_n)
			cyc <= cyc + 1;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic int seg_to_num(input logic [6:0] s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			7'b000_0000: return 10;   // blank
			default:     return BAD;
		endcase
	endfunction

	function automatic int to_secs(input int h, input int m, input int s);
		return h * 3600 + m * 60 + s;
	endfunction

	function automatic int time_diff(input int a, input int b);
		return ((a - b) % DAY + DAY) % DAY;
	endfunction

	function automatic logic [47:0] shadow_bits();
		logic [47:0] v;
		for (int i = 0; i < DIGITS; i++)
			v[7*i +: 7] = shadow_seg[i];
		v[47:42] = shadow_dp;
		return v;
	endfunction

	task automatic report_mismatch(input string msg);
		n_fail++;
		$display("[FAIL] %0t: %s", $time, msg);
	endtask

	task automatic report_timeout(input string what);
		n_timeout++;
		$display("Timed out waiting for %s at %0t", what, $time);
	endtask

	// Hold a button for 8 to 15 debounce periods, release as long
	task automatic press(input int b);
		int hold;
		hold = (8 + $urandom % 8) * DEB_DIV;
		@(posedge clk);
		#2 btn[b] = 1'b1;
		repeat (hold) @(posedge clk);
		#2 btn[b] = 1'b0;
		repeat (hold) @(posedge clk);
	endtask

	task automatic wait_refresh();
		int   base [DIGITS];
		int   t;
		logic done;
		base = upd_cnt;
		t    = 0;
		done = 1'b0;
		while (!done && t < 10 * DIGITS * SCAN_DIV) begin
			@(posedge clk);
			t++;
			done = 1'b1;
			for (int i = 0; i < DIGITS; i++) begin
				if (upd_cnt[i] == base[i])
					done = 1'b0;
			end
		end
		if (!done)
			report_timeout("a full display refresh");
	endtask

	// Two equal refreshes with every digit lit
	task automatic read_time(output int hh, output int mm, output int ss,
	                         output logic [5:0] dp);
		logic [47:0] snap_a;
		logic [47:0] snap_b;
		int          d [DIGITS];
		logic        good;
		int          tries;
		good  = 1'b0;
		tries = 0;
		hh    = 0;
		mm    = 0;
		ss    = 0;
		dp    = '0;
		while (!good && tries < 20) begin
			tries++;
			wait_refresh();
			snap_a = shadow_bits();
			wait_refresh();
			snap_b = shadow_bits();
			good = (snap_a == snap_b);
			for (int i = 0; i < DIGITS; i++) begin
				d[i] = seg_to_num(snap_b[7*i +: 7]);
				if (d[i] > 9)
					good = 1'b0;
			end
			ss = d[1] * 10 + d[0];
			mm = d[3] * 10 + d[2];
			hh = d[5] * 10 + d[4];
			dp = snap_b[47:42];
		end
		if (!good)
			report_timeout("a steady fully lit display");
	endtask

	task automatic check_hms(input string what, input int hh, input int mm, input int ss,
	                         input int eh, input int em, input int es);
		assert (hh == eh && mm == em && ss == es)
			else report_mismatch($sformatf("%s shows %0d:%0d:%0d, expected %0d:%0d:%0d",
			                               what, hh, mm, ss, eh, em, es));
	endtask

	// Selected field goes blank and lit, the others never blank
	task automatic check_blink(input int f);
		int b0 [DIGITS];
		int l0 [DIGITS];
		b0 = blank_cnt;
		l0 = lit_cnt;
		repeat (SEC_DIV + SEC_DIV / 4) @(posedge clk);
		for (int i = 0; i < DIGITS; i++) begin
			if (i / 2 == f) begin
				assert (blank_cnt[i] != b0[i] && lit_cnt[i] != l0[i])
					else report_mismatch($sformatf("digit %0d of field %0d did not blink", i, f));
			end else begin
				assert (blank_cnt[i] == b0[i])
					else report_mismatch($sformatf("digit %0d blanked with field %0d", i, f));
			end
		end
	endtask

	// ----------------------------------------
	// Display monitor
	// ----------------------------------------
	always @(negedge clk) begin
		if (rst_n && $onehot(~seg_enb)) begin
			scan_seen <= 1'b1;
			for (int i = 0; i < DIGITS; i++) begin
				if (!seg_enb[i]) begin
					shadow_seg[i] <= seg;
					shadow_dp[i]  <= seg_dp;
					upd_cnt[i]    <= upd_cnt[i] + 1;
					if (seg == 7'b000_0000)
						blank_cnt[i] <= blank_cnt[i] + 1;
					else
						lit_cnt[i] <= lit_cnt[i] + 1;
				end
			end
			assert (seg_to_num(seg) != BAD)
				else report_mismatch($sformatf("segment pattern %b is no digit", seg));
		end
	end

	// ----------------------------------------
	// Concurrent checks
	// ----------------------------------------
	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~seg_enb) || (seg_enb == 6'h3f && !scan_seen))
		else report_mismatch($sformatf("digit enables %b not one-hot low", seg_enb));

	assert property (@(posedge clk) disable iff (!rst_n) alarm_quiet |-> !alarm)
		else report_mismatch("alarm output high while it should be low");

	assert property (@(posedge clk) disable iff (!rst_n) alarm_hold |-> alarm)
		else report_mismatch("alarm output dropped while enabled");

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		int         hh, mm, ss, e, n;
		int         c_h, c_m, c_s;
		int         a_h, a_m, a_s;
		int         t_h, t_m, t_s;
		int         t_start, t;
		logic [5:0] dp;
		void'($urandom(32'hf712_404a));
		$timeformat(-9, 0, " ns", 0);

		// Reset state
		repeat (2) @(posedge clk);
		@(negedge clk);
		assert (seg_enb == 6'h3f && seg == 7'd0 && !seg_dp && !alarm)
			else report_mismatch("outputs not idle in reset");
		@(posedge clk);
		#2 rst_n = 1'b1;
		@(negedge clk);
		assert (seg_enb == 6'h3f)
			else report_mismatch("a digit enabled before the first scan");
		read_time(hh, mm, ss, dp);
		check_hms("reset", hh, mm, ss, 0, 0, 0);
		assert (dp == DP_CLK) else report_mismatch($sformatf("clock points %b", dp));

		// Timekeeping across the minute carry
		repeat (61 * SEC_DIV) @(posedge clk);
		read_time(hh, mm, ss, dp);
		e = cyc / SEC_DIV;
		n = to_secs(hh, mm, ss);
		assert (n <= e && n >= e - 1)
			else report_mismatch($sformatf("running time %0d s, expected %0d s", n, e));
		assert (hh == 0 && mm == 1) else report_mismatch("no carry into minutes");

		// Setup
		press(B_MODE);
		read_time(c_h, c_m, c_s, dp);
		assert (dp == DP_SET) else report_mismatch($sformatf("setup points %b", dp));
		repeat (SEC_DIV + SEC_DIV / 4) @(posedge clk);
		read_time(hh, mm, ss, dp);
		check_hms("frozen clock", hh, mm, ss, c_h, c_m, c_s);
		check_blink(0);
		n = 1 + $urandom % 6;
		repeat (n) press(B_INC);
		c_s = (c_s + n) % 60;
		press(B_POS);
		check_blink(1);
		n = 1 + $urandom % 6;
		repeat (n) press(B_INC);
		c_m = (c_m + n) % 60;
		press(B_POS);
		check_blink(2);
		n = 20 + $urandom % 8;       // mostly wraps past 23
		repeat (n) press(B_INC);
		c_h = (c_h + n) % 24;
		press(B_POS);
		read_time(hh, mm, ss, dp);
		check_hms("setup", hh, mm, ss, c_h, c_m, c_s);

		// Alarm set while the clock keeps running
		t_start = cyc;
		press(B_MODE);
		read_time(hh, mm, ss, dp);
		assert (dp == DP_ALM) else report_mismatch($sformatf("alarm points %b", dp));
		check_hms("initial alarm", hh, mm, ss, 0, 0, 0);
		a_s = 10 + $urandom % 20;
		a_m = $urandom % 6;
		a_h = $urandom % 4;
		repeat (a_s) press(B_INC);
		press(B_POS);
		repeat (a_m) press(B_INC);
		press(B_POS);
		repeat (a_h) press(B_INC);
		press(B_POS);
		read_time(hh, mm, ss, dp);
		check_hms("alarm", hh, mm, ss, a_h, a_m, a_s);
		press(B_MODE);
		read_time(hh, mm, ss, dp);
		assert (dp == DP_CLK) else report_mismatch($sformatf("clock points %b", dp));
		e = (cyc - t_start) / SEC_DIV;
		n = time_diff(to_secs(hh, mm, ss), to_secs(c_h, c_m, c_s));
		assert (n >= e - 1 && n <= e + 1)
			else report_mismatch($sformatf("clock ran %0d s in alarm mode, expected %0d s", n, e));

		// Clock set LEAD seconds before the alarm
		press(B_MODE);
		read_time(hh, mm, ss, dp);
		n   = (to_secs(a_h, a_m, a_s) - LEAD + DAY) % DAY;
		t_h = n / 3600;
		t_m = (n / 60) % 60;
		t_s = n % 60;
		repeat ((t_s - ss + 60) % 60) press(B_INC);
		press(B_POS);
		repeat ((t_m - mm + 60) % 60) press(B_INC);
		press(B_POS);
		repeat ((t_h - hh + 24) % 24) press(B_INC);
		press(B_POS);
		read_time(hh, mm, ss, dp);
		check_hms("clock before alarm", hh, mm, ss, t_h, t_m, t_s);

		// Alarm latch
		t_start = cyc;
		press(B_MODE);
		press(B_MODE);
		press(B_ALARM);
		alarm_quiet = 1'b0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!alarm && t < (LEAD + 3) * SEC_DIV);
		if (!alarm) begin
			report_timeout("the alarm output to rise");
		end else begin
			assert (cyc - t_start > (LEAD - 1) * SEC_DIV)
				else report_mismatch("alarm output rose before the alarm time");
			alarm_hold = 1'b1;
			read_time(hh, mm, ss, dp);
			n = time_diff(to_secs(hh, mm, ss), to_secs(a_h, a_m, a_s));
			assert (n <= 1)
				else report_mismatch($sformatf("alarm rose %0d s away from its time", n));
			repeat (2 * SEC_DIV) @(posedge clk);
			@(negedge clk);
			alarm_hold = 1'b0;
		end
		press(B_ALARM);
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (alarm && t < 64 * DEB_DIV);
		if (alarm)
			report_timeout("the alarm output to fall");
		alarm_quiet = 1'b1;
		repeat (SEC_DIV) @(posedge clk);

		$display("Checks done: %0d value errors, %0d timeouts", n_fail, n_timeout);
		if (n_fail == 0 && n_timeout == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- tick_gen.sv
/*
 * Tick generator
 * Divides clk into one-cycle enables for the second count,
 * digit scanning and button sampling, plus the blink phase
 */
`default_nettype none

module tick_gen #(
	parameter int SEC_DIV  = 50_000_000,
	parameter int SCAN_DIV = 5_000,
	parameter int DEB_DIV  = 500_000
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_sec_tick,
	output logic o_blink_on,
	output logic o_scan_tick,
	output logic o_deb_tick
);

	localparam int SEC_W  = $clog2(SEC_DIV);
	localparam int SCAN_W = $clog2(SCAN_DIV);
	localparam int DEB_W  = $clog2(DEB_DIV);

	logic [SEC_W-1:0]  sec_cnt;
	logic [SCAN_W-1:0] scan_cnt;
	logic [DEB_W-1:0]  deb_cnt;

	assign o_sec_tick  = (sec_cnt == SEC_W'(SEC_DIV - 1));
	assign o_scan_tick = (scan_cnt == SCAN_W'(SCAN_DIV - 1));
	assign o_deb_tick  = (deb_cnt == DEB_W'(DEB_DIV - 1));
	assign o_blink_on  = (sec_cnt >= SEC_W'(SEC_DIV / 2)); // second half of each second

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_cnt <= '0;
		end else if (o_sec_tick) begin
			sec_cnt <= '0;
		end else begin
			sec_cnt <= sec_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= '0;
		end else if (o_scan_tick) begin
			scan_cnt <= '0;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			deb_cnt <= '0;
		end else if (o_deb_tick) begin
			deb_cnt <= '0;
		end else begin
			deb_cnt <= deb_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- time_counters.sv
/*
 * Time and alarm registers
 * Clock time with second/minute/hour carries, field increments
 * in setup and alarm modes, and the alarm match latch
 */
`default_nettype none

module time_counters (
	input  wire              clk,
	input  wire              rst_n,
	input  wire              i_sec_tick,
	input  wire              i_inc_press,
	input  clock_pkg::mode_e i_mode,
	input  clock_pkg::pos_e  i_pos,
	input  wire              i_alarm_en,
	output clock_pkg::hms_t  o_clk_sec,
	output clock_pkg::hms_t  o_clk_min,
	output clock_pkg::hms_t  o_clk_hour,
	output clock_pkg::hms_t  o_al_sec,
	output clock_pkg::hms_t  o_al_min,
	output clock_pkg::hms_t  o_al_hour,
	output logic             o_alarm
);

	import clock_pkg::*;

	localparam hms_t SEC_TOP  = hms_t'(SEC_MAX);
	localparam hms_t MIN_TOP  = hms_t'(MIN_MAX);
	localparam hms_t HOUR_TOP = hms_t'(HOUR_MAX);

	logic match;

	function automatic hms_t inc_wrap(input hms_t v, input hms_t top);
		return (v == top) ? '0 : v + 1'b1;
	endfunction

	// ----------------------------------------
	// Clock time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_clk_sec  <= '0;
			o_clk_min  <= '0;
			o_clk_hour <= '0;
		end else if (i_mode == MODE_SETUP) begin
			if (i_inc_press) begin    // no carry while setting
				case (i_pos)
					POS_SEC:  o_clk_sec  <= inc_wrap(o_clk_sec, SEC_TOP);
					POS_MIN:  o_clk_min  <= inc_wrap(o_clk_min, MIN_TOP);
					POS_HOUR: o_clk_hour <= inc_wrap(o_clk_hour, HOUR_TOP);
					default: ;
				endcase
			end
		end else if (i_sec_tick) begin
			o_clk_sec <= inc_wrap(o_clk_sec, SEC_TOP);
			if (o_clk_sec == SEC_TOP) begin
				o_clk_min <= inc_wrap(o_clk_min, MIN_TOP);
				if (o_clk_min == MIN_TOP)
					o_clk_hour <= inc_wrap(o_clk_hour, HOUR_TOP);
			end
		end
	end

	// ----------------------------------------
	// Alarm time
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_al_sec  <= '0;
			o_al_min  <= '0;
			o_al_hour <= '0;
		end else if (i_mode == MODE_ALARM && i_inc_press) begin
			case (i_pos)
				POS_SEC:  o_al_sec  <= inc_wrap(o_al_sec, SEC_TOP);
				POS_MIN:  o_al_min  <= inc_wrap(o_al_min, MIN_TOP);
				POS_HOUR: o_al_hour <= inc_wrap(o_al_hour, HOUR_TOP);
				default: ;
			endcase
		end
	end

	assign match = (o_clk_sec == o_al_sec) && (o_clk_min == o_al_min) &&
	               (o_clk_hour == o_al_hour);

	// Set on match, held until the enable drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else
			o_alarm <= i_alarm_en & (o_alarm | match);
	end

endmodule

`default_nettype wire
